// File: tb.f
+incdir+design
design/dcache_axi_pkg.sv
design/dcache_ooo_pkg.sv
design/dcache_rd_arbiter.sv
design/dcache_ooo_tracker.sv
design/dcache_rd_path.sv
test/dcache_rd_path_props.sv
test/tb_dcache_rd_path.sv

// File: run.sh
#!/bin/sh
# Build and run the read path testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_dcache_rd_path -Mdir obj_dir
then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dcache_rd_path)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: test/tb_dcache_rd_path.sv
// Random requesters, a memory model that answers out of order, and an in-order scoreboard
// The memory model issues at most one completion per cycle, on the channel set by cache bit 1
`timescale 1ns/1ps

`include "dcache_config.svh"

module tb_dcache_rd_path
    import dcache_axi_pkg::*;
();

    localparam int TAGS = `DC_OSTD_NUM;

    logic     aclk;
    logic     aresetn;
    logic     io_arvalid;
    logic     io_arready;
    rd_addr_t io_ar;
    logic     blk_arvalid;
    logic     blk_arready;
    rd_addr_t blk_ar;
    logic     mem_arvalid;
    logic     mem_arready;
    rd_addr_t mem_ar;
    logic     mem_io_rvalid;
    rd_data_t mem_io_r;
    logic     mem_blk_rvalid;
    rd_data_t mem_blk_r;
    logic     app_rvalid;
    logic     app_rready;
    rd_data_t app_r;
    logic     pending_rd;

    integer seed;
    int     checks;
    int     mismatches;
    int     other_errs;

    // Stimulus knobs, percent chance per cycle
    int     io_rate;
    int     blk_rate;
    int     ar_rate;
    int     cpl_rate;
    int     rready_rate;
    logic   fair_mode;
    int     last_grant;
    int     alt_checks;
    logic   io_fired;
    logic   blk_fired;

    // Scoreboard in acceptance order
    int                   issued;
    int                   retired;
    logic [`DC_ID_W-1:0]  exp_oid[$];
    logic [`DC_TAG_W-1:0] exp_tag[$];
    // Memory model, tags still owed a completion
    logic [`DC_TAG_W-1:0] pend_tag[$];
    logic                 pend_io[$];
    logic [`DC_XLEN-1:0]  cpl_data[TAGS];
    logic [1:0]           cpl_resp[TAGS];
    logic                 cpl_done[TAGS];

    dcache_rd_path uut (.*);

    bind dcache_rd_path dcache_rd_path_props u_props (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_ar      (mem_ar),
        .app_rvalid  (app_rvalid),
        .app_rready  (app_rready),
        .app_r       (app_r),
        .tag_avlb    (tag_avlb),
        .pending_rd  (pending_rd)
    );

    always #2 aclk = ~aclk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = rand_word();
        return (r % 100) < pct;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // Handshakes seen at the rising edge, before any register moves
    task automatic sample();
        rd_addr_t             src;
        logic [`DC_ID_W-1:0]  exp_id;
        logic [`DC_TAG_W-1:0] head;
        io_fired  = io_arvalid && io_arready;
        blk_fired = blk_arvalid && blk_arready;
        if (mem_arvalid && mem_arready) begin
            src    = io_arready ? io_ar : blk_ar;
            exp_id = `DC_ID_W'(issued % TAGS) | `DC_ID_MASK;
            compare("grant_onehot", 64'(io_arready ^ blk_arready), 64'(1));
            compare("mem_ar.id", 64'(mem_ar.id), 64'(exp_id));
            compare("mem_ar.addr", 64'(mem_ar.addr), 64'(src.addr));
            compare("mem_ar.cache", 64'(mem_ar.cache), 64'(src.cache));
            // A fifth request needs the head entry returned first
            compare("tags_in_flight", 64'(issued - retired < TAGS), 64'(1));
            if (fair_mode && io_arvalid && blk_arvalid && last_grant >= 0) begin
                compare("io_arready_alternates", 64'(io_arready), 64'(last_grant != 0));
                alt_checks++;
            end
            last_grant = io_arready ? 0 : 1;
            exp_oid.push_back(src.id);
            exp_tag.push_back(mem_ar.id[`DC_TAG_W-1:0]);
            pend_tag.push_back(mem_ar.id[`DC_TAG_W-1:0]);
            pend_io.push_back(mem_ar.cache[1]);
            issued++;
        end
        if (app_rvalid && app_rready) begin
            if (exp_oid.size() == 0) begin
                report_failure("application return with no request outstanding");
            end else begin
                head   = exp_tag.pop_front();
                exp_id = exp_oid.pop_front();
                compare("app_r.id", 64'(app_r.id), 64'(exp_id));
                compare("completion_seen", 64'(cpl_done[head]), 64'(1));
                compare("app_r.resp", 64'(app_r.resp), 64'(cpl_resp[head]));
                compare("app_r.data", 64'(app_r.data), 64'(cpl_data[head]));
                cpl_done[head] = 1'b0;
            end
            retired++;
        end
    endtask

    // New inputs on the falling edge
    task automatic drive();
        logic [31:0] r;
        rd_data_t    cpl;
        int          idx;
        // Requesters hold valid and payload until their handshake
        if (!io_arvalid || io_fired) begin
            r           = rand_word();
            io_arvalid  = chance(io_rate);
            io_ar.addr  = `DC_ADDR_W'(r);
            io_ar.id    = `DC_ID_W'(r >> 8);
            io_ar.cache = {r[27:26], 1'b1, r[24]};
        end
        if (!blk_arvalid || blk_fired) begin
            r            = rand_word();
            blk_arvalid  = chance(blk_rate);
            blk_ar.addr  = `DC_ADDR_W'(r);
            blk_ar.id    = `DC_ID_W'(r >> 8);
            blk_ar.cache = {r[27:26], 1'b0, r[24]};
        end
        mem_arready    = chance(ar_rate);
        app_rready     = chance(rready_rate);
        mem_io_rvalid  = 1'b0;
        mem_blk_rvalid = 1'b0;
        // Complete any pending tag, picked at random
        if (pend_tag.size() > 0 && chance(cpl_rate)) begin
            idx      = int'(rand_word() % pend_tag.size());
            r        = rand_word();
            cpl.id   = `DC_ID_W'(pend_tag[idx]) | `DC_ID_MASK;
            cpl.resp = r[1:0];
            cpl.data = rand_word();
            cpl_data[pend_tag[idx]] = cpl.data;
            cpl_resp[pend_tag[idx]] = cpl.resp;
            cpl_done[pend_tag[idx]] = 1'b1;
            if (pend_io[idx]) begin
                mem_io_rvalid = 1'b1;
                mem_io_r      = cpl;
            end else begin
                mem_blk_rvalid = 1'b1;
                mem_blk_r      = cpl;
            end
            pend_tag.delete(idx);
            pend_io.delete(idx);
        end
    endtask

    task automatic step();
        @(posedge aclk);
        sample();
        @(negedge aclk);
        drive();
    endtask

    task automatic wait_issued(input int target, input int limit);
        int n;
        n = 0;
        while (issued < target && n < limit) begin
            step();
            n++;
        end
        if (issued < target) begin
            report_failure($sformatf("only %0d of %0d requests accepted", issued, target));
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((io_arvalid || blk_arvalid || exp_oid.size() != 0 || pending_rd) && n < limit) begin
            step();
            n++;
        end
        if (io_arvalid || blk_arvalid || exp_oid.size() != 0 || pending_rd) begin
            report_failure("read path did not drain");
        end
    endtask

    task automatic set_rates(input int io, input int blk, input int ar, input int cpl,
                             input int rdy);
        io_rate     = io;
        blk_rate    = blk;
        ar_rate     = ar;
        cpl_rate    = cpl;
        rready_rate = rdy;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed           = 32'he930_0059;
        aclk           = 1'b0;
        aresetn        = 1'b0;
        io_arvalid     = 1'b0;
        io_ar          = '0;
        blk_arvalid    = 1'b0;
        blk_ar         = '0;
        mem_arready    = 1'b0;
        mem_io_rvalid  = 1'b0;
        mem_io_r       = '0;
        mem_blk_rvalid = 1'b0;
        mem_blk_r      = '0;
        app_rready     = 1'b0;
        checks         = 0;
        mismatches     = 0;
        other_errs     = 0;
        issued         = 0;
        retired        = 0;
        fair_mode      = 1'b0;
        last_grant     = -1;
        alt_checks     = 0;
        io_fired       = 1'b0;
        blk_fired      = 1'b0;
        for (int i = 0; i < TAGS; i++) begin
            cpl_done[i] = 1'b0;
        end
        set_rates(0, 0, 0, 0, 0);

        repeat (8) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        // Idle outputs straight out of reset
        compare("mem_arvalid", 64'(mem_arvalid), 64'(0));
        compare("app_rvalid", 64'(app_rvalid), 64'(0));
        compare("pending_rd", 64'(pending_rd), 64'(0));
        compare("io_arready", 64'(io_arready), 64'(0));
        compare("blk_arready", 64'(blk_arready), 64'(0));

        // Fill all tags with completions held back
        set_rates(100, 0, 100, 0, 100);
        wait_issued(4, 50);
        repeat (12) begin
            step();
            compare("mem_arvalid_when_full", 64'(mem_arvalid), 64'(0));
            compare("issued_when_full", 64'(issued), 64'(4));
        end
        cpl_rate = 100;
        wait_issued(5, 100);
        compare("retired_before_fifth", 64'(retired >= 1), 64'(1));

        // Both requesters always valid, memory never stalls
        set_rates(100, 100, 100, 60, 100);
        fair_mode  = 1'b1;
        last_grant = -1;
        wait_issued(issued + 40, 1000);
        fair_mode = 1'b0;
        compare("alternation_seen", 64'(alt_checks >= 20), 64'(1));

        // Mixed random traffic with back-pressure everywhere
        set_rates(40, 40, 70, 35, 60);
        wait_issued(issued + 300, 6000);

        set_rates(0, 0, 100, 100, 100);
        wait_drain(500);
        compare("retired_count", 64'(retired), 64'(issued));
        compare("pending_rd_after_drain", 64'(pending_rd), 64'(0));
        compare("memory_left_pending", 64'(pend_tag.size()), 64'(0));

        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches,
                 other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: test/dcache_rd_path_props.sv
// Handshake hold rules and tag budget of the read path, bound into the top level
// The in-flight count is rebuilt from the memory request and application handshakes
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_rd_path_props
    import dcache_axi_pkg::*;
(
    input logic     aclk,
    input logic     aresetn,
    input logic     mem_arvalid,
    input logic     mem_arready,
    input rd_addr_t mem_ar,
    input logic     app_rvalid,
    input logic     app_rready,
    input rd_data_t app_r,
    input logic     tag_avlb,
    input logic     pending_rd
);

    // Reserved tags, up to DC_OSTD_NUM
    logic [$clog2(`DC_OSTD_NUM):0] inflight;
    logic                          ar_fire;
    logic                          r_fire;

    assign ar_fire = mem_arvalid && mem_arready;
    assign r_fire  = app_rvalid && app_rready;

    // Reserve and free both land one cycle after their handshake
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            inflight <= '0;
        end else if (ar_fire && !r_fire) begin
            inflight <= inflight + 1'b1;
        end else if (!ar_fire && r_fire) begin
            inflight <= inflight - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Properties
    ////////////////////////////////////////////////////////////

    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_ar))
        else $error("mem_ar dropped or changed while memory stalled");

    r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        app_rvalid && !app_rready |=> app_rvalid && $stable(app_r))
        else $error("app_r dropped or changed under back-pressure");

    // A free tag must be offered while the budget is not used up
    tag_budget: assert property (@(posedge aclk) disable iff (!aresetn)
        inflight < `DC_OSTD_NUM |-> tag_avlb)
        else $error("tag_avlb low with tags still free");

    pending_match: assert property (@(posedge aclk) disable iff (!aresetn)
        pending_rd == (inflight != 0))
        else $error("pending_rd disagrees with reserved tag count");

endmodule

// File: design/dcache_rd_path.sv
// Read path top: request arbiter in front of the out-of-order completion tracker
// Memory read-data channels are always ready and have no ready port
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_rd_path
    import dcache_axi_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,
    // I/O fetcher requests, uncached
    input  logic     io_arvalid,
    output logic     io_arready,
    input  rd_addr_t io_ar,
    // Block fetcher requests, cacheable
    input  logic     blk_arvalid,
    output logic     blk_arready,
    input  rd_addr_t blk_ar,
    // Memory address channel, id is the local tag
    output logic     mem_arvalid,
    input  logic     mem_arready,
    output rd_addr_t mem_ar,
    // Memory completions
    input  logic     mem_io_rvalid,
    input  rd_data_t mem_io_r,
    input  logic     mem_blk_rvalid,
    input  rd_data_t mem_blk_r,
    // Application return channel
    output logic     app_rvalid,
    input  logic     app_rready,
    output rd_data_t app_r,
    // Any read still in flight
    output logic     pending_rd
);

    logic [`DC_ID_W-1:0] next_tag;
    logic                tag_avlb;
    logic                req_fire;
    logic [`DC_ID_W-1:0] orig_id;
    rd_addr_t            req;

    ////////////////////////////////////////////////////////////
    // Request handoff to the tracker
    ////////////////////////////////////////////////////////////

    assign req_fire = mem_arvalid && mem_arready;

    // Granted source is the one whose ready is up at the handshake
    assign orig_id  = io_arready ? io_ar.id : blk_ar.id;

    // Same request as issued, with its original ID restored
    always_comb begin
        req    = mem_ar;
        req.id = orig_id;
    end

    dcache_rd_arbiter u_arbiter (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .io_arvalid  (io_arvalid),
        .io_arready  (io_arready),
        .io_ar       (io_ar),
        .blk_arvalid (blk_arvalid),
        .blk_arready (blk_arready),
        .blk_ar      (blk_ar),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_ar      (mem_ar),
        .tag_avlb    (tag_avlb),
        .next_tag    (next_tag)
    );

    dcache_ooo_tracker u_tracker (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .req_fire       (req_fire),
        .req            (req),
        .next_tag       (next_tag),
        .tag_avlb       (tag_avlb),
        .pending_rd     (pending_rd),
        .mem_io_rvalid  (mem_io_rvalid),
        .mem_io_r       (mem_io_r),
        .mem_blk_rvalid (mem_blk_rvalid),
        .mem_blk_r      (mem_blk_r),
        .app_rvalid     (app_rvalid),
        .app_rready     (app_rready),
        .app_r          (app_r)
    );

endmodule

// File: design/dcache_ooo_tracker.sv
// Tags are handed out and retired strictly in order; completions may land in any order
// Completion channels never stall; a completion to an unissued tag is flagged in simulation
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_ooo_tracker
    import dcache_axi_pkg::*;
    import dcache_ooo_pkg::*;
(
    input  logic                aclk,
    input  logic                aresetn,
    // Accepted request, carrying the original ID
    input  logic                req_fire,
    input  rd_addr_t            req,
    // Tag offer to the arbiter
    output logic [`DC_ID_W-1:0] next_tag,
    output logic                tag_avlb,
    output logic                pending_rd,
    // Memory completions, always accepted
    input  logic                mem_io_rvalid,
    input  rd_data_t            mem_io_r,
    input  logic                mem_blk_rvalid,
    input  rd_data_t            mem_blk_r,
    // In-order return to the application
    output logic                app_rvalid,
    input  logic                app_rready,
    output rd_data_t            app_r
);

    localparam int NB_TAG = `DC_OSTD_NUM;

    // Per-tag status and I/O marker
    tag_state_t          tag_st  [NB_TAG];
    logic [NB_TAG-1:0]   io_tag;
    // Original ID, then resp and data of each slot
    logic [`DC_ID_W-1:0] meta_id [NB_TAG];
    logic [1:0]          cpl_resp[NB_TAG];
    logic [`DC_XLEN-1:0] cpl_data[NB_TAG];

    // Issue pointer and retire pointer, wrap on overflow
    logic [`DC_TAG_W-1:0] req_pt;
    logic [`DC_TAG_W-1:0] cpl_pt;

    // Completion ids with the cache mask stripped
    logic [`DC_ID_W-1:0]  io_id_m;
    logic [`DC_ID_W-1:0]  blk_id_m;

    // Per-tag events this cycle
    logic [NB_TAG-1:0]    rsv_hit;
    logic [NB_TAG-1:0]    free_hit;
    logic [NB_TAG-1:0]    io_hit;
    logic [NB_TAG-1:0]    blk_hit;
    logic                 app_fire;

    ////////////////////////////////////////////////////////////
    // Tag offer and events
    ////////////////////////////////////////////////////////////

    assign next_tag = {{(`DC_ID_W-`DC_TAG_W){1'b0}}, req_pt} | `DC_ID_MASK;
    assign tag_avlb = (tag_st[req_pt] == FREE);

    assign io_id_m  = mem_io_r.id ^ `DC_ID_MASK;
    assign blk_id_m = mem_blk_r.id ^ `DC_ID_MASK;
    assign app_fire = app_rvalid && app_rready;

    always_comb begin
        pending_rd = 1'b0;
        for (int i = 0; i < NB_TAG; i++) begin
            rsv_hit[i]  = req_fire && (req_pt == `DC_TAG_W'(i));
            free_hit[i] = app_fire && (cpl_pt == `DC_TAG_W'(i));
            io_hit[i]   = mem_io_rvalid && (io_id_m[`DC_TAG_W-1:0] == `DC_TAG_W'(i));
            blk_hit[i]  = mem_blk_rvalid && (blk_id_m[`DC_TAG_W-1:0] == `DC_TAG_W'(i));
            // Anything not FREE still owes a return
            pending_rd  = pending_rd || (tag_st[i] != FREE);
        end
    end

    ////////////////////////////////////////////////////////////
    // Tag status
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < NB_TAG; i++) begin
                tag_st[i] <= FREE;
                io_tag[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NB_TAG; i++) begin
                if (rsv_hit[i]) begin
                    tag_st[i] <= RSVD;
                    io_tag[i] <= req.cache[1];
                end else if (free_hit[i]) begin
                    tag_st[i] <= FREE;
                    io_tag[i] <= 1'b0;
                end else if (io_hit[i] || blk_hit[i]) begin
                    // Set only the complete bit, a free tag turns ILGL
                    tag_st[i] <= tag_state_t'({1'b1, tag_st[i][0]});
                end
            end
        end
    end

    // Issue and retire pointers
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            req_pt <= '0;
            cpl_pt <= '0;
        end else begin
            if (req_fire) begin
                req_pt <= req_pt + 1'b1;
            end
            if (app_fire) begin
                cpl_pt <= cpl_pt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Meta and completion RAMs
    ////////////////////////////////////////////////////////////

    // I/O channel wins a same-slot collision
    always_ff @(posedge aclk) begin
        for (int i = 0; i < NB_TAG; i++) begin
            if (rsv_hit[i]) begin
                meta_id[i] <= req.id;
            end
            if (io_hit[i]) begin
                cpl_resp[i] <= mem_io_r.resp;
                cpl_data[i] <= mem_io_r.data;
            end else if (blk_hit[i]) begin
                cpl_resp[i] <= mem_blk_r.resp;
                cpl_data[i] <= mem_blk_r.data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Return to the application
    ////////////////////////////////////////////////////////////

    // Head entry is served once its completion is in
    assign app_rvalid = (tag_st[cpl_pt] == RCVD);

    always_comb begin
        app_r.id   = meta_id[cpl_pt];
        app_r.resp = cpl_resp[cpl_pt];
        app_r.data = cpl_data[cpl_pt];
    end

    // Simulation monitor for bad tag use
    always @(posedge aclk) begin
        if (aresetn) begin
            for (int i = 0; i < NB_TAG; i++) begin
                if (tag_st[i] == ILGL) begin
                    $error("dcache tracker: illegal status on tag %0d", i);
                end
                if ((io_hit[i] && !io_tag[i]) || (blk_hit[i] && io_tag[i])) begin
                    $error("dcache tracker: completion on wrong channel for tag %0d", i);
                end
            end
        end
    end

endmodule

// File: design/dcache_rd_arbiter.sv
// Combinational path from requesters to memory; only the priority is registered
// The issued id is always the tracker's next tag, never the original ID
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_rd_arbiter
    import dcache_axi_pkg::*;
    import dcache_ooo_pkg::*;
(
    input  logic                aclk,
    input  logic                aresetn,
    // I/O fetcher requests
    input  logic                io_arvalid,
    output logic                io_arready,
    input  rd_addr_t            io_ar,
    // Block fetcher requests
    input  logic                blk_arvalid,
    output logic                blk_arready,
    input  rd_addr_t            blk_ar,
    // Merged channel toward memory
    output logic                mem_arvalid,
    input  logic                mem_arready,
    output rd_addr_t            mem_ar,
    // Tag offered by the tracker
    input  logic                tag_avlb,
    input  logic [`DC_ID_W-1:0] next_tag
);

    grant_t prio;
    grant_t win;
    logic   mem_fire;

    ////////////////////////////////////////////////////////////
    // Grant selection
    ////////////////////////////////////////////////////////////

    // I/O wins when it has priority or block is idle
    always_comb begin
        if (io_arvalid && (prio == GNT_IO || !blk_arvalid)) begin
            win = GNT_IO;
        end else begin
            win = GNT_BLK;
        end
    end

    // No free tag means nothing goes out
    assign mem_arvalid = tag_avlb && (io_arvalid || blk_arvalid);
    assign mem_fire    = mem_arvalid && mem_arready;

    assign io_arready  = mem_arvalid && mem_arready && (win == GNT_IO);
    assign blk_arready = mem_arvalid && mem_arready && (win == GNT_BLK);

    // Forward the winner, original ID swapped for the local tag
    always_comb begin
        mem_ar    = (win == GNT_IO) ? io_ar : blk_ar;
        mem_ar.id = next_tag;
    end

    ////////////////////////////////////////////////////////////
    // Priority register
    ////////////////////////////////////////////////////////////

    // Flip away from the winner on acceptance
    // While memory stalls, pin the current winner so mem_ar holds
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            prio <= GNT_IO;
        end else if (mem_fire) begin
            prio <= (win == GNT_IO) ? GNT_BLK : GNT_IO;
        end else if (mem_arvalid) begin
            prio <= win;
        end
    end

endmodule

// File: design/dcache_ooo_pkg.sv
// Status and control encodings of the out-of-order read tracker

package dcache_ooo_pkg;

    // Per-tag status, bit 0 is the reserve bit, bit 1 the complete bit
    // ILGL means a completion landed on a tag never issued
    typedef enum logic [1:0] {
        FREE = 2'b00,
        RSVD = 2'b01,
        ILGL = 2'b10,
        RCVD = 2'b11
    } tag_state_t;

    // Which requester holds priority at the arbiter
    typedef enum logic {
        GNT_IO  = 1'b0,
        GNT_BLK = 1'b1
    } grant_t;

endpackage

// File: design/dcache_axi_pkg.sv
// AXI-style read channel payloads, without the valid/ready pair
// Widths follow the config header; no burst or user fields

`include "dcache_config.svh"

package dcache_axi_pkg;

    ////////////////////////////////////////////////////////////
    // Read address channel
    ////////////////////////////////////////////////////////////

    // One read request as it travels on an AR channel
    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_ID_W-1:0]   id;
        // Bit 1 set marks an uncached I/O access
        logic [3:0]            cache;
    } rd_addr_t;

    ////////////////////////////////////////////////////////////
    // Read data channel
    ////////////////////////////////////////////////////////////

    // One single-beat read completion
    typedef struct packed {
        logic [`DC_ID_W-1:0] id;
        logic [1:0]          resp;
        logic [`DC_XLEN-1:0] data;
    } rd_data_t;

endpackage

// File: design/dcache_config.svh
// Build-time sizing of the data cache read path
// DC_OSTD_NUM must be a power of two, and DC_TAG_W must equal its log2
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Data bus width in bits
`define DC_XLEN      32

// Address width of the read-address channel
`define DC_ADDR_W    8

// AXI ID width, shared by original IDs and issued tags
`define DC_ID_W      8

// Outstanding read tags, and the index width that walks them
`define DC_OSTD_NUM  4
`define DC_TAG_W     2

// Marks the data cache as the owner of an issued tag on the bus
`define DC_ID_MASK   8'h20

`endif
